/* hw/csr_pkg.sv */
// CSR unit package: base types, opcode, CSR op, address and cause enums, masks, reset values, structs
package csr_pkg;
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] rdata_t;
  typedef logic [XLEN-1:0] pc_t;
  typedef logic [11:0]     csr_addr_t;
  typedef logic [4:0]      reg_idx_t;

  // Major opcode of the system instruction space
  typedef enum logic [6:0] {
    OPC_SYSTEM = 7'b111_0011
  } opcode_e;

  // Encoded as funct3, so a CSR instruction maps straight onto this enum
  typedef enum logic [2:0] {
    CSR_OP_NONE = 3'b000,
    CSR_OP_RW   = 3'b001,
    CSR_OP_RS   = 3'b010,
    CSR_OP_RC   = 3'b011,
    CSR_OP_RWI  = 3'b101,
    CSR_OP_RSI  = 3'b110,
    CSR_OP_RCI  = 3'b111
  } csr_op_e;

  typedef enum logic [11:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MISA     = 12'h301,
    CSR_MIE      = 12'h304,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_MTVAL    = 12'h343,
    CSR_MIP      = 12'h344,
    CSR_CYCLE    = 12'hC00,
    CSR_CYCLEH   = 12'hC80,
    CSR_MHARTID  = 12'hF14
  } csr_addr_e;

  // Interrupt codes carry the top bit of mcause
  typedef enum logic [XLEN-1:0] {
    EXC_INSTR_MISALIGNED = 32'h0000_0000,
    EXC_ILLEGAL_INSTR    = 32'h0000_0002,
    EXC_BREAKPOINT       = 32'h0000_0003,
    EXC_ECALL_M          = 32'h0000_000B,
    IRQ_M_SW             = 32'h8000_0003,
    IRQ_M_TIMER          = 32'h8000_0007,
    IRQ_M_EXT            = 32'h8000_000B
  } exc_cause_e;

  // Full encodings of the privileged instructions
  localparam rdata_t INSTR_ECALL  = 32'h0000_0073;
  localparam rdata_t INSTR_EBREAK = 32'h0010_0073;
  localparam rdata_t INSTR_MRET   = 32'h3020_0073;

  localparam rdata_t MSTATUS_WMASK = 32'h807F_F9BB;
  localparam rdata_t MIE_WMASK     = 32'h0000_0888;
  localparam rdata_t MTVEC_WMASK   = 32'hFFFF_FFFD;
  localparam rdata_t MEPC_WMASK    = 32'hFFFF_FFFC;

  localparam rdata_t MSTATUS_RST = 32'h0000_1880;
  localparam rdata_t MTVEC_RST   = 32'h0000_1000;
  // RV32I, machine mode only
  localparam rdata_t MISA_VAL    = 32'h4000_0100;
  localparam rdata_t MHARTID_VAL = 32'h0000_0000;

  localparam int MST_MIE_BIT  = 3;
  localparam int MST_MPIE_BIT = 7;

  // Same positions in mie and mip
  localparam int IRQ_SW_BIT    = 3;
  localparam int IRQ_TIMER_BIT = 7;
  localparam int IRQ_EXT_BIT   = 11;

  localparam rdata_t VEC_OFF_SW    = 32'h0000_000C;
  localparam rdata_t VEC_OFF_TIMER = 32'h0000_001C;
  localparam rdata_t VEC_OFF_EXT   = 32'h0000_002C;

  typedef struct packed {
    logic sw;
    logic timer;
    logic ext;
  } s_irq_t;

  typedef struct packed {
    logic      valid;
    csr_op_e   op;
    csr_addr_t addr;
    reg_idx_t  rd;
    logic      rs1_is_x0;
    logic [4:0] uimm;
    logic      ecall;
    logic      ebreak;
    logic      mret;
    logic      illegal;
  } s_csr_cmd_t;

  typedef struct packed {
    logic   mst_mie;
    logic   mst_mpie;
    rdata_t mie;
    rdata_t mtvec;
    pc_t    mepc;
  } s_csr_view_t;

  typedef struct packed {
    logic   take;
    logic   is_mret;
    rdata_t cause;
    pc_t    epc;
    rdata_t tval;
    pc_t    target;
  } s_trap_req_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    rdata_t   data;
  } s_wb_t;

  typedef struct packed {
    logic active;
    pc_t  pc_addr;
  } s_trap_info_t;
endpackage

/* hw/csr_decode.sv */
// CSR decoder: SYSTEM instruction word to CSR command, privileged ops and illegal flag
`timescale 1ns/10ps
module csr_decode
  import csr_pkg::*;
(
  input  rdata_t     instr_i,
  input  logic       instr_valid_i,
  output s_csr_cmd_t cmd_o
);
  logic       is_system;
  logic       is_csr;
  logic       addr_ok;
  logic [2:0] funct3;
  csr_addr_t  csr_addr;
  csr_op_e    op;
  logic       is_ecall;
  logic       is_ebreak;
  logic       is_mret;

  always_comb begin
    funct3    = instr_i[14:12];
    csr_addr  = instr_i[31:20];
    is_system = (instr_i[6:0] == OPC_SYSTEM);

    // funct3 000 is the privileged group, 100 is reserved
    case (funct3)
      CSR_OP_RW,
      CSR_OP_RS,
      CSR_OP_RC,
      CSR_OP_RWI,
      CSR_OP_RSI,
      CSR_OP_RCI: op = is_system ? csr_op_e'(funct3) : CSR_OP_NONE;
      default:    op = CSR_OP_NONE;
    endcase
    is_csr = (op != CSR_OP_NONE);

    case (csr_addr)
      CSR_MSTATUS,
      CSR_MISA,
      CSR_MIE,
      CSR_MTVEC,
      CSR_MSCRATCH,
      CSR_MEPC,
      CSR_MCAUSE,
      CSR_MTVAL,
      CSR_MIP,
      CSR_CYCLE,
      CSR_CYCLEH,
      CSR_MHARTID: addr_ok = 1'b1;
      default:     addr_ok = 1'b0;
    endcase

    // Matched on the whole word, any other privileged form is illegal
    is_ecall  = (instr_i == INSTR_ECALL);
    is_ebreak = (instr_i == INSTR_EBREAK);
    is_mret   = (instr_i == INSTR_MRET);

    cmd_o.valid     = instr_valid_i;
    cmd_o.op        = op;
    cmd_o.addr      = csr_addr;
    cmd_o.rd        = instr_i[11:7];
    cmd_o.rs1_is_x0 = (instr_i[19:15] == 5'd0);
    cmd_o.uimm      = instr_i[19:15];
    cmd_o.ecall     = instr_valid_i && is_ecall;
    cmd_o.ebreak    = instr_valid_i && is_ebreak;
    cmd_o.mret      = instr_valid_i && is_mret;
    // Read-only write check needs rs1 data and is done in the CSR file
    cmd_o.illegal   = instr_valid_i &&
                      !(is_ecall || is_ebreak || is_mret || (is_csr && addr_ok));
  end
endmodule

/* hw/csr_trap_ctrl.sv */
// Trap controller: interrupt and exception priority, cause, epc, tval and redirect target
`timescale 1ns/10ps
module csr_trap_ctrl
  import csr_pkg::*;
(
  input  s_csr_cmd_t  cmd_i,
  input  pc_t         pc_i,
  input  rdata_t      instr_i,
  input  s_irq_t      irq_i,
  input  s_csr_view_t view_i,
  input  logic        ro_write_i,
  output s_trap_req_t trap_req_o
);
  logic        irq_en;
  logic        ext_pend;
  logic        sw_pend;
  logic        timer_pend;
  logic        pc_misaligned;
  logic        is_irq;
  exc_cause_e  cause;
  pc_t         mtvec_base;
  rdata_t      vec_off;
  s_trap_req_t req;

  always_comb begin
    // Interrupts only land on a valid instruction slot
    irq_en     = cmd_i.valid && view_i.mst_mie;
    ext_pend   = irq_en && irq_i.ext   && view_i.mie[IRQ_EXT_BIT];
    sw_pend    = irq_en && irq_i.sw    && view_i.mie[IRQ_SW_BIT];
    timer_pend = irq_en && irq_i.timer && view_i.mie[IRQ_TIMER_BIT];

    pc_misaligned = cmd_i.valid && (pc_i[1:0] != 2'b00);

    req   = '0;
    cause = EXC_INSTR_MISALIGNED;

    // Fixed priority: irqs first, then sync exceptions, then mret
    if (ext_pend) begin
      req.take = 1'b1;
      cause    = IRQ_M_EXT;
    end
    else if (sw_pend) begin
      req.take = 1'b1;
      cause    = IRQ_M_SW;
    end
    else if (timer_pend) begin
      req.take = 1'b1;
      cause    = IRQ_M_TIMER;
    end
    else if (cmd_i.illegal || ro_write_i) begin
      req.take = 1'b1;
      cause    = EXC_ILLEGAL_INSTR;
      req.tval = instr_i;
    end
    else if (pc_misaligned) begin
      req.take = 1'b1;
      cause    = EXC_INSTR_MISALIGNED;
      req.tval = pc_i;
    end
    else if (cmd_i.ecall) begin
      req.take = 1'b1;
      cause    = EXC_ECALL_M;
    end
    else if (cmd_i.ebreak) begin
      req.take = 1'b1;
      cause    = EXC_BREAKPOINT;
    end
    else if (cmd_i.mret) begin
      req.is_mret = 1'b1;
    end

    req.cause = cause;
    req.epc   = pc_i;

    // Target computation
    is_irq     = req.take && cause[XLEN-1];
    mtvec_base = {view_i.mtvec[XLEN-1:2], 2'b00};
    vec_off    = '0;

    if (view_i.mtvec[0] && is_irq) begin
      case (cause)
        IRQ_M_SW:    vec_off = VEC_OFF_SW;
        IRQ_M_TIMER: vec_off = VEC_OFF_TIMER;
        IRQ_M_EXT:   vec_off = VEC_OFF_EXT;
        default:     vec_off = '0;
      endcase
    end

    if (req.is_mret) begin
      req.target = view_i.mepc;
    end
    else begin
      req.target = mtvec_base + vec_off;
    end
  end

  assign trap_req_o = req;
endmodule

/* hw/csr_file.sv */
// Machine CSR file: registers, masked read-modify-write, trap updates, cycle counter, output flops
`timescale 1ns/10ps
module csr_file
  import csr_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n_i,
  input  s_csr_cmd_t   cmd_i,
  input  rdata_t       rs1_data_i,
  input  s_irq_t       irq_i,
  input  s_trap_req_t  trap_req_i,
  output s_csr_view_t  view_o,
  output logic         ro_write_o,
  output s_wb_t        wb_o,
  output s_trap_info_t trap_o,
  output rdata_t       mip_o
);
  rdata_t mstatus_ff,  next_mstatus;
  rdata_t mie_ff,      next_mie;
  rdata_t mtvec_ff,    next_mtvec;
  rdata_t mscratch_ff, next_mscratch;
  rdata_t mepc_ff,     next_mepc;
  rdata_t mcause_ff,   next_mcause;
  rdata_t mtval_ff,    next_mtval;
  rdata_t mip_ff,      next_mip;

  logic [2*XLEN-1:0] cycle_ff, next_cycle;

  s_wb_t        wb_ff,   next_wb;
  s_trap_info_t trap_ff, next_trap;

  logic   is_csr_op;
  logic   is_imm;
  logic   wr_req;
  logic   wr_en;
  logic   ro_addr;
  rdata_t src_val;
  rdata_t rd_val;

  function automatic rdata_t rmw_val(csr_op_e op, rdata_t old_val, rdata_t src,
                                     rdata_t mask);
    rdata_t val;

    case (op)
      CSR_OP_RW, CSR_OP_RWI: val = src;
      CSR_OP_RS, CSR_OP_RSI: val = old_val | src;
      CSR_OP_RC, CSR_OP_RCI: val = old_val & ~src;
      default:               val = old_val;
    endcase
    return val & mask;
  endfunction

  // Source operand and write qualification
  always_comb begin
    is_csr_op = cmd_i.valid && (cmd_i.op != CSR_OP_NONE);
    is_imm    = (cmd_i.op == CSR_OP_RWI) || (cmd_i.op == CSR_OP_RSI) ||
                (cmd_i.op == CSR_OP_RCI);

    if (is_imm) begin
      src_val = {{(XLEN-5){1'b0}}, cmd_i.uimm};
    end
    else begin
      src_val = cmd_i.rs1_is_x0 ? '0 : rs1_data_i;
    end

    // Set/clear forms with a zero source leave the CSR untouched
    wr_req = is_csr_op && ((cmd_i.op == CSR_OP_RW) || (cmd_i.op == CSR_OP_RWI) ||
                           (src_val != '0));

    case (cmd_i.addr)
      CSR_MCAUSE, CSR_CYCLE, CSR_CYCLEH, CSR_MISA, CSR_MHARTID: ro_addr = 1'b1;
      default:                                                  ro_addr = 1'b0;
    endcase
  end

  assign ro_write_o = wr_req && ro_addr;

  always_comb begin
    wr_en = wr_req && !trap_req_i.take;

    next_mstatus  = mstatus_ff;
    next_mie      = mie_ff;
    next_mtvec    = mtvec_ff;
    next_mscratch = mscratch_ff;
    next_mepc     = mepc_ff;
    next_mcause   = mcause_ff;
    next_mtval    = mtval_ff;
    next_cycle    = cycle_ff + 1'b1;

    // mip only mirrors the request levels
    next_mip                = '0;
    next_mip[IRQ_SW_BIT]    = irq_i.sw;
    next_mip[IRQ_TIMER_BIT] = irq_i.timer;
    next_mip[IRQ_EXT_BIT]   = irq_i.ext;

    case (cmd_i.addr)
      CSR_MSTATUS:  rd_val = mstatus_ff;
      CSR_MIE:      rd_val = mie_ff;
      CSR_MTVEC:    rd_val = mtvec_ff;
      CSR_MSCRATCH: rd_val = mscratch_ff;
      CSR_MEPC:     rd_val = mepc_ff;
      CSR_MCAUSE:   rd_val = mcause_ff;
      CSR_MTVAL:    rd_val = mtval_ff;
      CSR_MIP:      rd_val = mip_ff;
      CSR_CYCLE:    rd_val = cycle_ff[XLEN-1:0];
      CSR_CYCLEH:   rd_val = cycle_ff[2*XLEN-1:XLEN];
      CSR_MISA:     rd_val = MISA_VAL;
      CSR_MHARTID:  rd_val = MHARTID_VAL;
      default:      rd_val = '0;
    endcase

    if (wr_en) begin
      case (cmd_i.addr)
        CSR_MSTATUS:  next_mstatus  = rmw_val(cmd_i.op, rd_val, src_val, MSTATUS_WMASK);
        CSR_MIE:      next_mie      = rmw_val(cmd_i.op, rd_val, src_val, MIE_WMASK);
        CSR_MTVEC:    next_mtvec    = rmw_val(cmd_i.op, rd_val, src_val, MTVEC_WMASK);
        CSR_MSCRATCH: next_mscratch = rmw_val(cmd_i.op, rd_val, src_val, '1);
        CSR_MEPC:     next_mepc     = rmw_val(cmd_i.op, rd_val, src_val, MEPC_WMASK);
        CSR_MTVAL:    next_mtval    = rmw_val(cmd_i.op, rd_val, src_val, '1);
        default:      ;
      endcase
    end

    // Trap entry stacks MIE into MPIE
    if (trap_req_i.take) begin
      next_mepc                  = trap_req_i.epc;
      next_mcause                = trap_req_i.cause;
      next_mtval                 = trap_req_i.tval;
      next_mstatus[MST_MPIE_BIT] = mstatus_ff[MST_MIE_BIT];
      next_mstatus[MST_MIE_BIT]  = 1'b0;
    end
    else if (trap_req_i.is_mret) begin
      next_mstatus[MST_MIE_BIT]  = mstatus_ff[MST_MPIE_BIT];
      next_mstatus[MST_MPIE_BIT] = 1'b1;
    end

    next_wb.valid = is_csr_op && !trap_req_i.take && (cmd_i.rd != '0);
    next_wb.rd    = cmd_i.rd;
    next_wb.data  = rd_val;

    next_trap.active  = trap_req_i.take || trap_req_i.is_mret;
    next_trap.pc_addr = trap_req_i.target;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mstatus_ff  <= MSTATUS_RST;
      mie_ff      <= '0;
      mtvec_ff    <= MTVEC_RST;
      mscratch_ff <= '0;
      mepc_ff     <= '0;
      mcause_ff   <= '0;
      mtval_ff    <= '0;
      mip_ff      <= '0;
      cycle_ff    <= '0;
      wb_ff       <= '0;
      trap_ff     <= '0;
    end
    else begin
      mstatus_ff  <= next_mstatus;
      mie_ff      <= next_mie;
      mtvec_ff    <= next_mtvec;
      mscratch_ff <= next_mscratch;
      mepc_ff     <= next_mepc;
      mcause_ff   <= next_mcause;
      mtval_ff    <= next_mtval;
      mip_ff      <= next_mip;
      cycle_ff    <= next_cycle;
      wb_ff       <= next_wb;
      trap_ff     <= next_trap;
    end
  end

  // Trap controller sees the current register state
  assign view_o.mst_mie  = mstatus_ff[MST_MIE_BIT];
  assign view_o.mst_mpie = mstatus_ff[MST_MPIE_BIT];
  assign view_o.mie      = mie_ff;
  assign view_o.mtvec    = mtvec_ff;
  assign view_o.mepc     = mepc_ff;

  assign wb_o   = wb_ff;
  assign trap_o = trap_ff;
  assign mip_o  = mip_ff;
endmodule

/* hw/csr_unit_top.sv */
// CSR unit top level: decode, trap controller and CSR file
`timescale 1ns/10ps
module csr_unit_top
  import csr_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n_i,
  input  rdata_t       instr_i,
  input  logic         instr_valid_i,
  input  pc_t          pc_i,
  input  rdata_t       rs1_data_i,
  input  s_irq_t       irq_i,
  output s_wb_t        wb_o,
  output s_trap_info_t trap_o,
  output rdata_t       mip_o
);
  s_csr_cmd_t  csr_cmd;
  s_csr_view_t csr_view;
  s_trap_req_t trap_req;
  logic        ro_write;

  csr_decode u_csr_decode (
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .cmd_o         (csr_cmd)
  );

  csr_trap_ctrl u_csr_trap_ctrl (
    .cmd_i      (csr_cmd),
    .pc_i       (pc_i),
    .instr_i    (instr_i),
    .irq_i      (irq_i),
    .view_i     (csr_view),
    .ro_write_i (ro_write),
    .trap_req_o (trap_req)
  );

  // Writeback and redirect leave through the CSR file flops
  csr_file u_csr_file (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .cmd_i      (csr_cmd),
    .rs1_data_i (rs1_data_i),
    .irq_i      (irq_i),
    .trap_req_i (trap_req),
    .view_o     (csr_view),
    .ro_write_o (ro_write),
    .wb_o       (wb_o),
    .trap_o     (trap_o),
    .mip_o      (mip_o)
  );
endmodule

/* test/tb_clk_gen.sv */
// Testbench clock and reset generator
`timescale 1ns/10ps
module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic arst_n_o
);
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release lands on a falling edge, away from the flops
  initial begin
    arst_n_o = 1'b0;
    #(PERIOD_NS * RST_CYCLES);
    arst_n_o = 1'b1;
  end
endmodule

/* test/csr_ref_model.svh */
// Reference model of the machine CSR state and the per-instruction prediction
rdata_t      ref_mstatus;
rdata_t      ref_mie;
rdata_t      ref_mtvec;
rdata_t      ref_mscratch;
rdata_t      ref_mepc;
rdata_t      ref_mcause;
rdata_t      ref_mtval;
rdata_t      ref_mip;
logic [63:0] ref_cycle;

logic     exp_wb_valid;
reg_idx_t exp_wb_rd;
rdata_t   exp_wb_data;
logic     exp_trap_active;
pc_t      exp_trap_pc;

task automatic reset_model();
  ref_mstatus  = MSTATUS_RST;
  ref_mie      = '0;
  ref_mtvec    = MTVEC_RST;
  ref_mscratch = '0;
  ref_mepc     = '0;
  ref_mcause   = '0;
  ref_mtval    = '0;
  ref_mip      = '0;
  // One edge has passed when the first instruction is driven
  ref_cycle    = 64'd1;
endtask

function automatic logic is_known_csr(csr_addr_t a);
  case (a)
    CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC,
    CSR_MCAUSE, CSR_MTVAL, CSR_MIP, CSR_CYCLE, CSR_CYCLEH, CSR_MHARTID: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

function automatic logic is_ro_csr(csr_addr_t a);
  case (a)
    CSR_MCAUSE, CSR_CYCLE, CSR_CYCLEH, CSR_MISA, CSR_MHARTID: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

function automatic rdata_t csr_value(csr_addr_t a);
  case (a)
    CSR_MSTATUS:  return ref_mstatus;
    CSR_MIE:      return ref_mie;
    CSR_MTVEC:    return ref_mtvec;
    CSR_MSCRATCH: return ref_mscratch;
    CSR_MEPC:     return ref_mepc;
    CSR_MCAUSE:   return ref_mcause;
    CSR_MTVAL:    return ref_mtval;
    CSR_MIP:      return ref_mip;
    CSR_CYCLE:    return ref_cycle[31:0];
    CSR_CYCLEH:   return ref_cycle[63:32];
    CSR_MISA:     return MISA_VAL;
    CSR_MHARTID:  return MHARTID_VAL;
    default:      return '0;
  endcase
endfunction

// Low funct3 bits: 01 write, 10 set, 11 clear
function automatic rdata_t apply_op(logic [1:0] kind, rdata_t old, rdata_t src, rdata_t mask);
  case (kind)
    2'b01:   return src & mask;
    2'b10:   return (old | src) & mask;
    default: return (old & ~src) & mask;
  endcase
endfunction

task automatic predict_step(input rdata_t instr, input logic valid, input pc_t pc,
                            input rdata_t rs1, input s_irq_t irq);
  logic       csr;
  logic       ecall;
  logic       ebreak;
  logic       mret;
  logic       illegal;
  logic       wr;
  logic       take;
  logic       do_mret;
  logic       en;
  logic [2:0] f3;
  logic [4:0] rs1_idx;
  csr_addr_t  addr;
  reg_idx_t   rd;
  rdata_t     src;
  rdata_t     old;
  rdata_t     cause;
  rdata_t     tval;

  f3      = instr[14:12];
  addr    = instr[31:20];
  rd      = instr[11:7];
  rs1_idx = instr[19:15];
  ecall   = (instr == 32'h0000_0073);
  ebreak  = (instr == 32'h0010_0073);
  mret    = (instr == 32'h3020_0073);
  csr     = valid && (instr[6:0] == 7'h73) && (f3 != 3'b000) && (f3 != 3'b100);
  illegal = valid && !(ecall || ebreak || mret || (csr && is_known_csr(addr)));
  src     = f3[2] ? {27'd0, rs1_idx} : ((rs1_idx == 5'd0) ? '0 : rs1);
  wr      = csr && ((f3[1:0] == 2'b01) || (src != '0));
  old     = csr_value(addr);
  en      = valid && ref_mstatus[MST_MIE_BIT];

  take    = 1'b1;
  do_mret = 1'b0;
  tval    = '0;
  cause   = '0;
  if (en && irq.ext && ref_mie[11]) cause = 32'h8000_000B;
  else if (en && irq.sw && ref_mie[3]) cause = 32'h8000_0003;
  else if (en && irq.timer && ref_mie[7]) cause = 32'h8000_0007;
  else if (illegal || (wr && is_ro_csr(addr))) begin
    cause = 32'd2;
    tval  = instr;
  end
  else if (valid && (pc[1:0] != 2'b00)) begin
    cause = 32'd0;
    tval  = pc;
  end
  else if (valid && ecall) cause = 32'd11;
  else if (valid && ebreak) cause = 32'd3;
  else begin
    take    = 1'b0;
    do_mret = valid && mret;
  end

  exp_trap_active = take || do_mret;
  exp_trap_pc     = do_mret ? ref_mepc : {ref_mtvec[31:2], 2'b00};
  if (take && cause[31] && ref_mtvec[0]) begin
    case (cause[3:0])
      4'd3:    exp_trap_pc = exp_trap_pc + 32'h0C;
      4'd7:    exp_trap_pc = exp_trap_pc + 32'h1C;
      default: exp_trap_pc = exp_trap_pc + 32'h2C;
    endcase
  end
  exp_wb_valid = csr && !take && (rd != 5'd0);
  exp_wb_rd    = rd;
  exp_wb_data  = old;

  if (wr && !take) begin
    case (addr)
      CSR_MSTATUS:  ref_mstatus  = apply_op(f3[1:0], old, src, MSTATUS_WMASK);
      CSR_MIE:      ref_mie      = apply_op(f3[1:0], old, src, MIE_WMASK);
      CSR_MTVEC:    ref_mtvec    = apply_op(f3[1:0], old, src, MTVEC_WMASK);
      CSR_MSCRATCH: ref_mscratch = apply_op(f3[1:0], old, src, 32'hFFFF_FFFF);
      CSR_MEPC:     ref_mepc     = apply_op(f3[1:0], old, src, MEPC_WMASK);
      CSR_MTVAL:    ref_mtval    = apply_op(f3[1:0], old, src, 32'hFFFF_FFFF);
      default:      ;
    endcase
  end
  if (take) begin
    ref_mepc                  = pc;
    ref_mcause                = cause;
    ref_mtval                 = tval;
    ref_mstatus[MST_MPIE_BIT] = ref_mstatus[MST_MIE_BIT];
    ref_mstatus[MST_MIE_BIT]  = 1'b0;
  end
  else if (do_mret) begin
    ref_mstatus[MST_MIE_BIT]  = ref_mstatus[MST_MPIE_BIT];
    ref_mstatus[MST_MPIE_BIT] = 1'b1;
  end

  ref_mip     = '0;
  ref_mip[3]  = irq.sw;
  ref_mip[7]  = irq.timer;
  ref_mip[11] = irq.ext;
  ref_cycle   = ref_cycle + 64'd1;
endtask

/* test/tb_csr_unit.sv */
// Testbench top for the CSR unit: directed and random instructions checked against a model
`timescale 1ns/10ps
module tb_csr_unit
  import csr_pkg::*;
;
  // Upper bound on issued instructions over all tests
  localparam int MAX_STEPS = 500;
  localparam int LIMIT     = 2 * MAX_STEPS + 16 + 64;
  localparam pc_t BASE_PC  = 32'h0000_0100;

  logic         clk;
  logic         arst_n;
  rdata_t       instr_i;
  logic         instr_valid_i;
  pc_t          pc_i;
  rdata_t       rs1_data_i;
  s_irq_t       irq_i;
  s_wb_t        wb_o;
  s_trap_info_t trap_o;
  rdata_t       mip_o;

  int     n_checks;
  int     n_errors;
  int     test_err_start;
  int     cyc_count;
  rdata_t last_data;

  tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(16)) u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  csr_unit_top u_dut (
    .clk           (clk),
    .arst_n_i      (arst_n),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .pc_i          (pc_i),
    .rs1_data_i    (rs1_data_i),
    .irq_i         (irq_i),
    .wb_o          (wb_o),
    .trap_o        (trap_o),
    .mip_o         (mip_o)
  );

  `include "csr_ref_model.svh"

  task automatic check(input string name, input rdata_t exp, input rdata_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("Error %s expected %h actual %h", name, exp, act);
    end
  endtask

  function automatic rdata_t csr_word(logic [2:0] f3, csr_addr_t addr, reg_idx_t rs1,
                                      reg_idx_t rd);
    return {addr, rs1, f3, rd, 7'h73};
  endfunction

  // Drives one slot, then checks the registered outputs one edge later
  task automatic step(input string name, input rdata_t instr, input logic valid,
                      input pc_t pc, input rdata_t rs1, input s_irq_t irq);
    instr_i       = instr;
    instr_valid_i = valid;
    pc_i          = pc;
    rs1_data_i    = rs1;
    irq_i         = irq;
    predict_step(instr, valid, pc, rs1, irq);
    @(posedge clk);
    #1;
    check({name, " wb.valid"}, exp_wb_valid, wb_o.valid);
    if (exp_wb_valid) begin
      check({name, " wb.rd"}, exp_wb_rd, wb_o.rd);
      check({name, " wb.data"}, exp_wb_data, wb_o.data);
    end
    check({name, " trap.active"}, exp_trap_active, trap_o.active);
    if (exp_trap_active) begin
      check({name, " trap.pc"}, exp_trap_pc, trap_o.pc_addr);
    end
    check({name, " mip"}, ref_mip, mip_o);
    last_data = wb_o.data;
  endtask

  task automatic read_csr(input string name, input csr_addr_t addr);
    step(name, csr_word(3'b010, addr, 5'd0, 5'd1), 1'b1, BASE_PC, '0, '0);
  endtask

  task automatic write_csr(input string name, input csr_addr_t addr, input rdata_t val);
    step(name, csr_word(3'b001, addr, 5'd5, 5'd0), 1'b1, BASE_PC, val, '0);
  endtask

  task automatic end_test(input string name);
    $display("test %s done with %0d errors", name, n_errors - test_err_start);
    test_err_start = n_errors;
  endtask

  always @(posedge clk) begin
    cyc_count++;
    if (cyc_count >= LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    integer    seed;
    integer    i;
    integer    r;
    rdata_t    saved;
    rdata_t    word;
    pc_t       pc;
    reg_idx_t  rs1_idx;
    reg_idx_t  rd;
    logic [2:0] f3;
    csr_addr_t addrs [12];
    rdata_t    exc_words [5];
    pc_t       exc_pcs [5];

    seed           = 87;
    n_checks       = 0;
    n_errors       = 0;
    test_err_start = 0;
    cyc_count      = 0;
    instr_i        = '0;
    instr_valid_i  = 1'b0;
    pc_i           = '0;
    rs1_data_i     = '0;
    irq_i          = '0;
    addrs = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MTVAL,
              CSR_MCAUSE, CSR_MIP, CSR_CYCLE, CSR_CYCLEH, CSR_MISA, CSR_MHARTID};
    exc_words = '{INSTR_ECALL, INSTR_EBREAK, 32'hFFFF_FFFF,
                  csr_word(3'b001, CSR_MCAUSE, 5'd2, 5'd1),
                  csr_word(3'b010, CSR_MSCRATCH, 5'd0, 5'd1)};
    exc_pcs = '{BASE_PC, BASE_PC, BASE_PC, BASE_PC, BASE_PC | 32'h2};

    wait (arst_n === 1'b1);
    @(posedge clk);
    #1;
    reset_model();

    for (i = 0; i < 3; i++) step("reset_idle", '0, 1'b0, BASE_PC, '0, '0);
    read_csr("reset_mstatus", CSR_MSTATUS);
    check("reset_mstatus", MSTATUS_RST, last_data);
    read_csr("reset_mtvec", CSR_MTVEC);
    check("reset_mtvec", MTVEC_RST, last_data);
    read_csr("reset_misa", CSR_MISA);
    check("reset_misa", MISA_VAL, last_data);
    read_csr("reset_mhartid", CSR_MHARTID);
    check("reset_mhartid", MHARTID_VAL, last_data);
    end_test("reset");

    // Writable CSRs only, irqs held low
    for (i = 0; i < 100; i++) begin
      r       = $random(seed);
      f3      = (r[2:0] == 3'b000 || r[2:0] == 3'b100) ? 3'b001 : r[2:0];
      rs1_idx = (r[4:3] == 2'b00) ? 5'd0 : r[9:5];
      rd      = (r[11:10] == 2'b00) ? 5'd0 : r[16:12];
      word    = csr_word(f3, addrs[(r[31:20] & 12'hFFF) % 6], rs1_idx, rd);
      step("csr_rmw", word, 1'b1, BASE_PC, $random(seed), '0);
    end
    for (i = 0; i < 6; i++) read_csr("csr_rmw_readback", addrs[i]);
    end_test("csr_rmw");

    write_csr("exc_setup", CSR_MTVEC, BASE_PC);
    for (i = 0; i < 5; i++) begin
      write_csr("exc_mie_off", CSR_MIE, '0);
      step("exc_set_mie", csr_word(3'b110, CSR_MSTATUS, 5'd8, 5'd0), 1'b1, BASE_PC, '0, '0);
      step("exc_issue", exc_words[i], 1'b1, exc_pcs[i], 32'h5, '0);
      check("exc_target", BASE_PC, trap_o.pc_addr);
      read_csr("exc_mepc", CSR_MEPC);
      read_csr("exc_mcause", CSR_MCAUSE);
      read_csr("exc_mtval", CSR_MTVAL);
      read_csr("exc_mstatus", CSR_MSTATUS);
    end
    end_test("exceptions");

    write_csr("irq_mie", CSR_MIE, 32'h888);
    write_csr("irq_mtvec", CSR_MTVEC, 32'h201);
    step("irq_set_mie", csr_word(3'b110, CSR_MSTATUS, 5'd8, 5'd0), 1'b1, BASE_PC, '0, '0);
    step("irq_all", csr_word(3'b010, CSR_MSCRATCH, 5'd0, 5'd1), 1'b1, BASE_PC, '0, 3'b111);
    check("irq_target", 32'h22C, trap_o.pc_addr);
    step("irq_mip", csr_word(3'b010, CSR_MIP, 5'd0, 5'd1), 1'b1, BASE_PC, '0, 3'b111);
    check("irq_mip", 32'h888, last_data);
    read_csr("irq_mcause", CSR_MCAUSE);
    end_test("interrupts");

    // mepc holds the pc of the interrupted slot
    read_csr("mret_mepc", CSR_MEPC);
    step("mret", INSTR_MRET, 1'b1, BASE_PC, '0, '0);
    check("mret_target", BASE_PC, trap_o.pc_addr);
    read_csr("mret_mstatus", CSR_MSTATUS);
    check("mret_mie_mpie", 32'h3, {last_data[MST_MPIE_BIT], last_data[MST_MIE_BIT]});
    end_test("mret");

    read_csr("cycle_first", CSR_CYCLE);
    saved = last_data;
    read_csr("cycle_second", CSR_CYCLE);
    check("cycle_increasing", 32'h1, last_data > saved);
    read_csr("cycleh", CSR_CYCLEH);
    check("cycleh", '0, last_data);
    end_test("cycle");

    for (i = 0; i < 300; i++) begin
      r       = $random(seed);
      f3      = (r[2:0] == 3'b000 || r[2:0] == 3'b100) ? 3'b010 : r[2:0];
      rs1_idx = (r[4:3] == 2'b00) ? 5'd0 : r[9:5];
      rd      = (r[11:10] == 2'b00) ? 5'd0 : r[16:12];
      case (r[20:17])
        4'd0:    word = INSTR_ECALL;
        4'd1:    word = INSTR_EBREAK;
        4'd2:    word = INSTR_MRET;
        4'd3:    word = $random(seed);
        default: word = csr_word(f3, addrs[(r[31:24] & 8'hFF) % 12], rs1_idx, rd);
      endcase
      pc = (r[23:21] == 3'd0) ? (BASE_PC | r[22:21] | 32'h1) : BASE_PC;
      step("random", word, r[26:24] != 3'd0, pc, $random(seed),
           (r[28:27] == 2'd0) ? s_irq_t'(r[31:29]) : s_irq_t'(3'b000));
    end
    end_test("random");

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end
    else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end
endmodule

/* list.f */
+incdir+test
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_trap_ctrl.sv
hw/csr_file.sv
hw/csr_unit_top.sv
test/tb_clk_gen.sv
test/tb_csr_unit.sv
